//--- sm83_alu_stim.txt
// Columns op a b sel res flags cond with two hex digits each
// Flags nibble holds Z N H C from bit 3 down and op ff ends the list
00 3a c6 00 00 0b 00
01 12 34 00 47 00 00
02 00 01 00 ff 07 00
03 05 02 00 02 04 00
07 42 50 00 42 05 00
08 ff 00 00 00 0b 00
09 01 00 00 00 0d 00
04 f0 0f 00 00 0a 00
06 81 18 00 99 00 00
05 a5 0f 00 aa 00 00
0c 33 00 00 33 01 00
0a 35 00 00 ca 07 00
10 00 85 00 0b 01 00
11 00 01 00 80 01 00
12 00 80 00 01 01 00
13 00 01 00 80 01 00
14 00 80 00 00 09 00
15 00 81 00 c0 01 00
17 00 01 00 00 09 00
16 00 f1 00 1f 00 00
0c 00 00 00 00 01 00
18 00 7f 07 00 0b 00
18 00 01 00 00 03 00
1a 00 00 03 08 03 00
19 00 ff 07 7f 03 00
00 45 38 00 7d 00 00
0b 7d 00 00 83 00 00
00 99 01 00 9a 00 00
0b 9a 00 00 00 09 00
02 42 15 00 2d 06 00
0b 2d 00 00 27 04 00
0d 00 00 00 00 01 00
0d 00 00 00 00 00 00
0e 00 a0 00 00 0a 00
0f 00 00 00 00 0a 00
0f 00 00 01 00 0a 01
0e 00 10 00 00 01 00
0f 00 00 02 00 01 00
0f 00 00 03 00 01 01
ff 00 00 00 00 00 00

//--- vlog.f
sm83_alu_pkg.sv
sm83_flag_pkg.sv
sm83_cla_adder.sv
sm83_shifter.sv
sm83_flag_logic.sv
sm83_alu.sv
tb_sm83_alu.sv

//--- Makefile
# Verilator build and run of the SM83 ALU testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f vlog.f --top-module tb_sm83_alu -Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_sm83_alu.sv
module tb_sm83_alu;
	import sm83_alu_pkg::*;
	import sm83_flag_pkg::*;

	localparam int         FIELDS    = 7;	// op a b sel res flags cond
	localparam int         MAX_LINES = 64;
	localparam logic [7:0] END_MARK  = 8'hff;	// Op byte of the closing line

	logic             clk;
	logic             arst_n;
	logic             in_valid;
	logic             in_ready;
	alu_op_t          op;
	data_t            a;
	data_t            b;
	logic [SEL_W-1:0] sel;
	logic             out_valid;
	logic             out_ready;
	data_t            res;
	flags_t           flags;
	logic             cond;

	logic [7:0]  stim_mem [0:MAX_LINES*FIELDS-1];
	int          n_lines;
	int          next_line;	// Next line to present
	int          n_taken;
	int          expect_q[$];	// Accepted, result not yet taken
	logic [31:0] lfsr;
	bit          loaded;

	sm83_alu dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.op        (op),
		.a         (a),
		.b         (b),
		.sel       (sel),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.res       (res),
		.flags     (flags),
		.cond      (cond)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// Taps 32 22 2 1
	endfunction

	task automatic take_bit(output logic bit_out);
		bit_out = lfsr[0];
		lfsr    = lfsr_step(lfsr);
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_res(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			stop_run($sformatf("error %s res expected %02h actual %02h", name, exp, act));
		end
	endtask

	task automatic check_flags(input string name, input flags_t exp, input flags_t act);
		if (act !== exp) begin
			stop_run($sformatf("error %s flags expected %01h actual %01h", name, exp, act));
		end
	endtask

	task automatic check_cond(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_run($sformatf("error %s cond expected %0b actual %0b", name, exp, act));
		end
	endtask

	task automatic present_line(input int idx);
		int base;
		base = idx * FIELDS;
		op   = alu_op_t'(stim_mem[base][4:0]);
		a    = stim_mem[base+1];
		b    = stim_mem[base+2];
		sel  = stim_mem[base+3][SEL_W-1:0];
	endtask

	task automatic check_output(input int idx);
		int    base;
		string name;
		base = idx * FIELDS;
		name = $sformatf("line %0d", idx + 1);	// Data lines counted from 1
		check_res(name, data_t'(stim_mem[base+4]), res);
		check_flags(name, flags_t'(stim_mem[base+5][FLAG_W-1:0]), flags);
		check_cond(name, stim_mem[base+6][0], cond);
	endtask

	initial begin
		logic fire_in;
		logic fire_out;
		logic gate;
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		op        = OP_ADD;
		a         = '0;
		b         = '0;
		sel       = '0;
		lfsr      = 32'h3d00a951;
		next_line = 0;
		n_taken   = 0;
		$readmemh("sm83_alu_stim.txt", stim_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim_mem[n_lines*FIELDS] != END_MARK) n_lines++;
		if (n_lines == 0) stop_run("the stimulus file holds no operations");
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		if (out_valid !== 1'b0) stop_run("out_valid is high after reset");
		check_flags("reset", '0, flags);
		check_res("reset", '0, res);
		while (n_taken < n_lines) begin
			@(negedge clk);	// Mid cycle, all levels settled
			// Slot full exactly when one accepted result is still pending
			if (out_valid !== (expect_q.size() != 0)) begin
				stop_run("out_valid does not follow the accepted operations");
			end
			if (in_ready !== (expect_q.size() == 0 || out_ready)) begin
				stop_run("in_ready is wrong for the state of the output register");
			end
			fire_in  = in_valid & in_ready;
			fire_out = out_valid & out_ready;
			if (fire_out) begin
				check_output(expect_q.pop_front());
				n_taken++;
			end
			if (fire_in) begin
				expect_q.push_back(next_line);
				next_line++;
			end
			@(posedge clk);
			#1;
			if (!in_valid || fire_in) begin	// Held while stalled
				take_bit(gate);
				in_valid = gate && (next_line < n_lines);
				if (in_valid) present_line(next_line);
			end
			take_bit(gate);
			out_ready = gate;
		end
		@(negedge clk);
		if (out_valid === 1'b0) begin
			$display("Test passed");
			$finish;
		end else begin
			stop_run("out_valid is still high after the last result was taken");
		end
	end

	initial begin
		int cycles;
		int limit;
		cycles = 0;
		wait (loaded);
		limit = 8 * n_lines + 50;	// Generous for half-rate valid and ready
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= limit) begin
				stop_run($sformatf("the unit stalled, %0d of %0d results after %0d cycles",
					n_taken, n_lines, cycles));
			end
		end
	end

endmodule

//--- sm83_alu.sv
module sm83_alu (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           in_valid,
	output logic                           in_ready,
	input  sm83_alu_pkg::alu_op_t          op,
	input  sm83_alu_pkg::data_t            a,	// A, INC/DEC/CPL/DAA operand
	input  sm83_alu_pkg::data_t            b,	// Second operand, CB group target
	input  logic [sm83_alu_pkg::SEL_W-1:0] sel,
	output logic                           out_valid,
	input  logic                           out_ready,
	output sm83_alu_pkg::data_t            res,
	output sm83_flag_pkg::flags_t          flags,
	output logic                           cond
);
	import sm83_alu_pkg::*;
	import sm83_flag_pkg::*;

	logic   accept;
	logic   is_sub;
	logic   is_incdec;
	logic   is_carry_op;
	data_t  add_y;
	logic   carry_in;
	data_t  sum;
	logic   half_carry;
	logic   carry_out;
	data_t  shifted;
	logic   shift_carry;
	data_t  bit_mask;
	data_t  daa_res;
	data_t  res_d;
	logic   cond_d;
	flags_t flags_q;
	flags_t flags_next;
	flags_t flags_we;

	// Output slot free or draining this cycle
	assign in_ready = ~out_valid | out_ready;
	assign accept   = in_valid & in_ready;

	assign is_sub      = op inside {OP_SUB, OP_SBC, OP_CP, OP_DEC};
	assign is_incdec   = op inside {OP_INC, OP_DEC};
	assign is_carry_op = op inside {OP_ADC, OP_SBC};

	// Subtract as a + ~y + 1, SBC feeds ~C in place of the 1
	assign add_y    = (is_incdec ? data_t'(1) : b) ^ {DATA_W{is_sub}};
	assign carry_in = is_sub ^ (is_carry_op & flags_q[FLAG_C]);
	assign bit_mask = data_t'(1) << sel;	// One-hot for SET and RES

	sm83_cla_adder u_adder (
		.x          (a),
		.y          (add_y),
		.carry_in   (carry_in),
		.sum        (sum),
		.half_carry (half_carry),
		.carry_out  (carry_out)
	);

	sm83_shifter u_shifter (
		.op        (op),
		.data      (b),
		.carry_in  (flags_q[FLAG_C]),
		.shifted   (shifted),
		.carry_out (shift_carry)
	);

	sm83_flag_logic u_flag_logic (
		.op          (op),
		.a           (a),
		.b           (b),
		.sel         (sel),
		.flags_q     (flags_q),
		.sum         (sum),
		.half_carry  (half_carry),
		.carry_out   (carry_out),
		.shifted     (shifted),
		.shift_carry (shift_carry),
		.flags_next  (flags_next),
		.flags_we    (flags_we),
		.daa_res     (daa_res),
		.cond        (cond_d)
	);

	always_comb begin
		case (op)
			OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_INC, OP_DEC: res_d = sum;
			OP_AND: res_d = a & b;
			OP_XOR: res_d = a ^ b;
			OP_OR:  res_d = a | b;
			OP_CPL: res_d = ~a;
			OP_RLC, OP_RRC, OP_RL, OP_RR, OP_SLA, OP_SRA, OP_SWAP, OP_SRL: res_d = shifted;
			OP_SET: res_d = b | bit_mask;
			OP_RES: res_d = b & ~bit_mask;
			OP_DAA: res_d = daa_res;
			default: res_d = a;	// CP, BIT, SCF, CCF, CHK, LDF leave A as is
		endcase
	end

	// F is written with the same edge that loads the output slot
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags_q <= '0;
		end else if (accept) begin
			flags_q <= (flags_q & ~flags_we) | (flags_next & flags_we);
		end
	end

	assign flags = flags_q;	// Stable while the slot is held

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			res       <= '0;
			cond      <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
			res       <= res_d;
			cond      <= cond_d;
		end else if (out_ready) begin
			out_valid <= 1'b0;	// Taken, nothing new
		end
	end

endmodule

//--- sm83_flag_logic.sv
module sm83_flag_logic (
	input  sm83_alu_pkg::alu_op_t           op,
	input  sm83_alu_pkg::data_t             a,
	input  sm83_alu_pkg::data_t             b,
	input  logic [sm83_alu_pkg::SEL_W-1:0]  sel,
	input  sm83_flag_pkg::flags_t           flags_q,
	input  sm83_alu_pkg::data_t             sum,
	input  logic                            half_carry,
	input  logic                            carry_out,
	input  sm83_alu_pkg::data_t             shifted,
	input  logic                            shift_carry,
	output sm83_flag_pkg::flags_t           flags_next,
	output sm83_flag_pkg::flags_t           flags_we,
	output sm83_alu_pkg::data_t             daa_res,
	output logic                            cond
);
	import sm83_alu_pkg::*;
	import sm83_flag_pkg::*;

	logic  z_q;
	logic  n_q;
	logic  h_q;
	logic  c_q;
	logic  daa_lo;	// Low digit needs 0x06
	logic  daa_hi;	// High digit needs 0x60, also the new C
	data_t daa_corr;
	cc_t   cc;
	logic  cond_hit;

	assign z_q = flags_q[FLAG_Z];
	assign n_q = flags_q[FLAG_N];
	assign h_q = flags_q[FLAG_H];
	assign c_q = flags_q[FLAG_C];

	// After a subtraction only the recorded borrows count
	assign daa_lo   = h_q | (~n_q & (a[HALF_W-1:0] > BCD_MAX_DIGIT));
	assign daa_hi   = c_q | (~n_q & (a > BCD_MAX_BYTE));
	assign daa_corr = ({DATA_W{daa_hi}} & DAA_CORR_HI) | ({DATA_W{daa_lo}} & DAA_CORR_LO);
	assign daa_res  = n_q ? (a - daa_corr) : (a + daa_corr);

	always_comb begin
		flags_next = '0;	// N and H mostly clear
		flags_we   = '0;	// SET, RES and CHK keep F
		case (op)
			OP_ADD, OP_ADC: begin
				flags_next[FLAG_Z] = ~|sum;
				flags_next[FLAG_H] = half_carry;
				flags_next[FLAG_C] = carry_out;
				flags_we           = MASK_Z | MASK_N | MASK_H | MASK_C;
			end
			OP_SUB, OP_SBC, OP_CP: begin
				flags_next[FLAG_Z] = ~|sum;
				flags_next[FLAG_N] = 1'b1;
				flags_next[FLAG_H] = ~half_carry;	// Borrow from bit 4
				flags_next[FLAG_C] = ~carry_out;
				flags_we           = MASK_Z | MASK_N | MASK_H | MASK_C;
			end
			OP_INC: begin
				flags_next[FLAG_Z] = ~|sum;
				flags_next[FLAG_H] = half_carry;
				flags_we           = MASK_Z | MASK_N | MASK_H;	// C untouched
			end
			OP_DEC: begin
				flags_next[FLAG_Z] = ~|sum;
				flags_next[FLAG_N] = 1'b1;
				flags_next[FLAG_H] = ~half_carry;
				flags_we           = MASK_Z | MASK_N | MASK_H;
			end
			OP_AND: begin
				flags_next[FLAG_Z] = ~|(a & b);
				flags_next[FLAG_H] = 1'b1;
				flags_we           = MASK_Z | MASK_N | MASK_H | MASK_C;
			end
			OP_OR, OP_XOR: begin
				flags_next[FLAG_Z] = (op == OP_OR) ? ~|(a | b) : ~|(a ^ b);
				flags_we           = MASK_Z | MASK_N | MASK_H | MASK_C;
			end
			OP_CPL: begin
				flags_next[FLAG_N] = 1'b1;
				flags_next[FLAG_H] = 1'b1;
				flags_we           = MASK_N | MASK_H;
			end
			OP_RLC, OP_RRC, OP_RL, OP_RR, OP_SLA, OP_SRA, OP_SWAP, OP_SRL: begin
				flags_next[FLAG_Z] = ~|shifted;
				flags_next[FLAG_C] = shift_carry;
				flags_we           = MASK_Z | MASK_N | MASK_H | MASK_C;
			end
			OP_BIT: begin
				flags_next[FLAG_Z] = ~b[sel];
				flags_next[FLAG_H] = 1'b1;
				flags_we           = MASK_Z | MASK_N | MASK_H;
			end
			OP_DAA: begin
				flags_next[FLAG_Z] = ~|daa_res;
				flags_next[FLAG_C] = daa_hi;
				flags_we           = MASK_Z | MASK_H | MASK_C;	// N survives
			end
			OP_SCF, OP_CCF: begin
				flags_next[FLAG_C] = (op == OP_SCF) | ~c_q;
				flags_we           = MASK_N | MASK_H | MASK_C;
			end
			OP_LDF: begin
				flags_next = b[LDF_FLAG_LSB +: FLAG_W];	// As POP AF
				flags_we   = MASK_Z | MASK_N | MASK_H | MASK_C;
			end
			default: begin
			end
		endcase
	end

	assign cc = cc_t'(sel[1:0]);

	always_comb begin
		case (cc)
			CC_NZ: cond_hit = ~z_q;
			CC_Z:  cond_hit = z_q;
			CC_NC: cond_hit = ~c_q;
			CC_C:  cond_hit = c_q;
		endcase
	end

	assign cond = (op == OP_CHK) & cond_hit;	// Low for every other code

endmodule

//--- sm83_shifter.sv
module sm83_shifter (
	input  sm83_alu_pkg::alu_op_t op,
	input  sm83_alu_pkg::data_t   data,
	input  logic                  carry_in,	// Old C flag for RL and RR
	output sm83_alu_pkg::data_t   shifted,
	output logic                  carry_out
);
	import sm83_alu_pkg::*;

	always_comb begin
		shifted   = data;	// Pass through for non-shift codes
		carry_out = 1'b0;
		case (op)
			OP_RLC: begin
				shifted   = {data[DATA_W-2:0], data[DATA_W-1]};
				carry_out = data[DATA_W-1];
			end
			OP_RRC: begin
				shifted   = {data[0], data[DATA_W-1:1]};
				carry_out = data[0];
			end
			OP_RL: begin
				shifted   = {data[DATA_W-2:0], carry_in};	// Rotate through C
				carry_out = data[DATA_W-1];
			end
			OP_RR: begin
				shifted   = {carry_in, data[DATA_W-1:1]};
				carry_out = data[0];
			end
			OP_SLA: begin
				shifted   = {data[DATA_W-2:0], 1'b0};
				carry_out = data[DATA_W-1];
			end
			OP_SRA: begin
				shifted   = {data[DATA_W-1], data[DATA_W-1:1]};	// Sign bit kept
				carry_out = data[0];
			end
			OP_SRL: begin
				shifted   = {1'b0, data[DATA_W-1:1]};
				carry_out = data[0];
			end
			OP_SWAP: begin
				shifted   = {data[HALF_W-1:0], data[DATA_W-1:HALF_W]};	// C cleared
				carry_out = 1'b0;
			end
			default: begin
			end
		endcase
	end

endmodule

//--- sm83_cla_adder.sv
module sm83_cla_adder (
	input  sm83_alu_pkg::data_t x,
	input  sm83_alu_pkg::data_t y,	// Already complemented for subtraction
	input  logic                carry_in,
	output sm83_alu_pkg::data_t sum,
	output logic                half_carry,
	output logic                carry_out
);
	import sm83_alu_pkg::*;

	data_t             g;	// Generate terms
	data_t             p;	// Propagate terms
	logic [HALF_W-1:0] c_lo;	// Carries out of bits 0..3
	logic [HALF_W-1:0] c_hi;	// Carries out of bits 4..7

	// Flat lookahead over one nibble, carries into bits 1..4
	function automatic logic [HALF_W-1:0] cla4(
		input logic [HALF_W-1:0] gn,
		input logic [HALF_W-1:0] pn,
		input logic              cin
	);
		logic [HALF_W-1:0] c;
		c[0] = gn[0] | (pn[0] & cin);
		c[1] = gn[1] | (pn[1] & gn[0]) | (pn[1] & pn[0] & cin);
		c[2] = gn[2]
			| (pn[2] & gn[1])
			| (pn[2] & pn[1] & gn[0])
			| (pn[2] & pn[1] & pn[0] & cin);
		c[3] = gn[3]
			| (pn[3] & gn[2])
			| (pn[3] & pn[2] & gn[1])
			| (pn[3] & pn[2] & pn[1] & gn[0])
			| (pn[3] & pn[2] & pn[1] & pn[0] & cin);
		return c;
	endfunction

	assign g = x & y;
	assign p = x ^ y;	// XOR form doubles as the half sum

	assign c_lo = cla4(g[HALF_W-1:0], p[HALF_W-1:0], carry_in);
	assign c_hi = cla4(g[DATA_W-1:HALF_W], p[DATA_W-1:HALF_W], c_lo[HALF_W-1]);	// Chained

	// Incoming carry of each bit
	assign sum = p ^ {c_hi[HALF_W-2:0], c_lo, carry_in};

	assign half_carry = c_lo[HALF_W-1];	// Carry from bit 3
	assign carry_out  = c_hi[HALF_W-1];	// Carry from bit 7

endmodule

//--- sm83_flag_pkg.sv
package sm83_flag_pkg;

	localparam int FLAG_W = 4;

	typedef logic [FLAG_W-1:0] flags_t;	// {Z, N, H, C}

	// Same order as the upper nibble of F
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 2;
	localparam int FLAG_H = 1;
	localparam int FLAG_C = 0;

	localparam int LDF_FLAG_LSB = 4;	// Flags sit in b[7:4] for LDF

	// One-hot write masks
	localparam flags_t MASK_Z = flags_t'(1 << FLAG_Z);
	localparam flags_t MASK_N = flags_t'(1 << FLAG_N);
	localparam flags_t MASK_H = flags_t'(1 << FLAG_H);
	localparam flags_t MASK_C = flags_t'(1 << FLAG_C);

	// Encoding of IR[4:3] in JR/JP/CALL/RET cc
	typedef enum logic [1:0] {
		CC_NZ = 2'b00,
		CC_Z  = 2'b01,
		CC_NC = 2'b10,
		CC_C  = 2'b11
	} cc_t;

endpackage

//--- sm83_alu_pkg.sv
package sm83_alu_pkg;

	localparam int DATA_W = 8;	// Operand and result width
	localparam int HALF_W = DATA_W / 2;	// Nibble, boundary of the half carry
	localparam int SEL_W  = 3;	// Bit index for BIT, SET, RES

	typedef logic [DATA_W-1:0] data_t;

	// BCD correction terms for DAA
	localparam data_t             DAA_CORR_LO   = 8'h06;
	localparam data_t             DAA_CORR_HI   = 8'h60;
	localparam data_t             BCD_MAX_BYTE  = 8'h99;	// Above this the high digit overflows
	localparam logic [HALF_W-1:0] BCD_MAX_DIGIT = 4'h9;

	// Low eight codes follow the SM83 ALU group order
	typedef enum logic [4:0] {
		OP_ADD  = 5'h00,
		OP_ADC  = 5'h01,	// Add with C
		OP_SUB  = 5'h02,
		OP_SBC  = 5'h03,	// Subtract with borrow
		OP_AND  = 5'h04,
		OP_XOR  = 5'h05,
		OP_OR   = 5'h06,
		OP_CP   = 5'h07,	// SUB flags, A kept
		OP_INC  = 5'h08,
		OP_DEC  = 5'h09,
		OP_CPL  = 5'h0a,	// Complement A
		OP_DAA  = 5'h0b,
		OP_SCF  = 5'h0c,
		OP_CCF  = 5'h0d,
		OP_LDF  = 5'h0e,	// Flags from b[7:4]
		OP_CHK  = 5'h0f,	// Condition test only
		// CB group, same order as the opcode map
		OP_RLC  = 5'h10,
		OP_RRC  = 5'h11,
		OP_RL   = 5'h12,
		OP_RR   = 5'h13,
		OP_SLA  = 5'h14,
		OP_SRA  = 5'h15,
		OP_SWAP = 5'h16,
		OP_SRL  = 5'h17,
		OP_BIT  = 5'h18,
		OP_RES  = 5'h19,
		OP_SET  = 5'h1a
	} alu_op_t;

endpackage
